/* all.f */
verilog/dotp_pkg.sv
verilog/dotp_input_sampler.sv
verilog/dotp_weight_buffer.sv
verilog/dotp_mac_array.sv
verilog/dotp_requantizer.sv
verilog/dotp_output_fifo.sv
verilog/dotp_engine.sv
test/tb_dotp_engine.sv

/* run.sh */
#!/bin/sh
# Compile the engine and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module tb_dotp_engine \
  --Mdir obj_dir -o tb_dotp_engine \
  -f all.f

./obj_dir/tb_dotp_engine

/* test/tb_dotp_engine.sv */
// Testbench for the tiled matrix-vector engine with an operation table,
// LFSR stimulus, reference model, scoreboard and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_dotp_engine;
  import dotp_pkg::*;

  localparam int NumRows = 8;
  localparam logic [1:0] ModeRand = 2'd0;
  localparam logic [1:0] ModeMax  = 2'd1;
  localparam logic [1:0] ModeMin  = 2'd2;

  typedef struct packed {
    ctrl_t      ctrl;
    logic [1:0] mode;
    logic [3:0] ops;
    logic       long_stalls;
  } op_row_t;

  logic    clk_i;
  logic    rst_ni;
  ctrl_t   ctrl_i;
  logic    inp_valid_i;
  logic    inp_ready_o;
  inp_t    inp_i;
  logic    weight_valid_i;
  logic    weight_ready_o;
  weight_t weight_i;
  logic    bias_valid_i;
  logic    bias_ready_o;
  bias_t   bias_i;
  logic    valid_o;
  logic    ready_i;
  oup_t    oup_o;
  logic    busy_o;

  op_row_t     op_table [NumRows];
  logic [31:0] lfsr_state;
  inp_t        inp_fifo [$];
  weight_t     wgt_fifo [$];
  bias_t       bias_fifo [$];
  oup_t        expected_q [$];
  logic        long_stalls;
  int          stall_left;

  dotp_engine #(.N(N), .M(M), .FifoDepth(FifoDepth)) u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_i         (ctrl_i),
    .inp_valid_i    (inp_valid_i),
    .inp_ready_o    (inp_ready_o),
    .inp_i          (inp_i),
    .weight_valid_i (weight_valid_i),
    .weight_ready_o (weight_ready_o),
    .weight_i       (weight_i),
    .bias_valid_i   (bias_valid_i),
    .bias_ready_o   (bias_ready_o),
    .bias_i         (bias_i),
    .valid_o        (valid_o),
    .ready_i        (ready_i),
    .oup_o          (oup_o),
    .busy_o         (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int unsigned width);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < width; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic int8_t lane_value(input logic [1:0] mode, input logic is_weight);
    if (mode == ModeRand) begin
      return int8_t'(rand_bits(8));
    end
    // Min mode pairs -128 inputs with +127 weights
    if (mode == ModeMin && !is_weight) begin
      return -8'sd128;
    end
    return 8'sd127;
  endfunction

  function automatic acc_t bias_value(input logic [1:0] mode);
    logic [15:0] r;
    if (mode == ModeMax) begin
      return 24'sd1048576;
    end
    if (mode == ModeMin) begin
      return -24'sd1048576;
    end
    r = rand_bits(16);
    return acc_t'($signed(r));
  endfunction

  // Multiply, floor shift, offset, saturate
  function automatic oup_t expected_output(input acc_vec_t acc, input ctrl_t c);
    oup_t   res;
    longint v;
    for (int m = 0; m < M; m++) begin
      v = longint'(acc[m]) * longint'(c.eps_mult);
      v = v >>> c.right_shift;
      v = v + longint'($signed(c.add));
      if (v > 127) begin
        res[m] = 8'sd127;
      end else if (v < -128) begin
        res[m] = -8'sd128;
      end else begin
        res[m] = int8_t'(v);
      end
    end
    return res;
  endfunction

  task automatic fill_table();
    op_table[0] = '{'{4'd1, 8'd64, 5'd12, 8'sd3}, ModeRand, 4'd3, 1'b0};
    op_table[1] = '{'{4'd1, 8'd200, 5'd14, -8'sd5}, ModeRand, 4'd2, 1'b0};
    op_table[2] = '{'{4'd4, 8'd128, 5'd16, 8'sd0}, ModeRand, 4'd2, 1'b0};
    op_table[3] = '{'{4'd15, 8'd17, 5'd15, 8'sd10}, ModeRand, 4'd1, 1'b0};
    op_table[4] = '{'{4'd2, 8'd255, 5'd0, 8'sd0}, ModeMax, 4'd1, 1'b0};
    op_table[5] = '{'{4'd3, 8'd255, 5'd2, -8'sd20}, ModeMin, 4'd1, 1'b0};
    // More results than FIFO entries and long output stalls
    op_table[6] = '{'{4'd1, 8'd90, 5'd13, 8'sd1}, ModeRand, 4'd6, 1'b1};
    op_table[7] = '{'{4'd2, 8'd33, 5'd11, -8'sd1}, ModeRand, 4'd5, 1'b1};
  endtask

  // Stimulus and expected results for all operations of one row
  task automatic build_row(input op_row_t row);
    acc_vec_t acc;
    bias_t    b;
    inp_t     x;
    weight_t  w;
    for (int op = 0; op < row.ops; op++) begin
      for (int m = 0; m < M; m++) begin
        b[m] = bias_value(row.mode);
      end
      bias_fifo.push_back(b);
      acc = b;
      for (int t = 0; t < row.ctrl.tiles; t++) begin
        for (int n = 0; n < N; n++) begin
          x[n] = lane_value(row.mode, 1'b0);
        end
        for (int m = 0; m < M; m++) begin
          for (int n = 0; n < N; n++) begin
            w[m][n] = lane_value(row.mode, 1'b1);
            acc[m] = acc[m] + acc_t'(int'(x[n]) * int'(w[m][n]));
          end
        end
        inp_fifo.push_back(x);
        wgt_fifo.push_back(w);
      end
      expected_q.push_back(expected_output(acc, row.ctrl));
    end
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "Value mismatch on %s", what);
    end
  endtask

  task automatic present_item(input int which);
    case (which)
      0: begin
        inp_i = inp_fifo.pop_front();
        inp_valid_i = 1'b1;
      end
      1: begin
        weight_i = wgt_fifo.pop_front();
        weight_valid_i = 1'b1;
      end
      default: begin
        bias_i = bias_fifo.pop_front();
        bias_valid_i = 1'b1;
      end
    endcase
  endtask

  task automatic drop_valid(input int which);
    case (which)
      0:       inp_valid_i = 1'b0;
      1:       weight_valid_i = 1'b0;
      default: bias_valid_i = 1'b0;
    endcase
  endtask

  // Samples ready mid-cycle and returns just after the transfer edge
  task automatic wait_accept(input int which);
    logic ok;
    ok = 1'b0;
    while (!ok) begin
      @(negedge clk_i);
      case (which)
        0:       ok = inp_ready_o;
        1:       ok = weight_ready_o;
        default: ok = bias_ready_o;
      endcase
      @(posedge clk_i);
    end
  endtask

  task automatic send_stream(input int which, input int count);
    int unsigned gap;
    for (int i = 0; i < count; i++) begin
      gap = rand_bits(2);
      if (gap != 0) begin
        #1;
        drop_valid(which);
        repeat (gap) @(posedge clk_i);
      end
      #1;
      present_item(which);
      wait_accept(which);
    end
    #1;
    drop_valid(which);
  endtask

  // Output ready with short random gaps or long stalls
  initial begin
    ready_i = 1'b0;
    stall_left = 0;
    @(posedge rst_ni);
    forever begin
      @(posedge clk_i);
      #1;
      if (stall_left > 0) begin
        ready_i = 1'b0;
        stall_left--;
      end else if (long_stalls && ready_i) begin
        ready_i = 1'b0;
        stall_left = 8 + int'(rand_bits(4));
      end else begin
        ready_i = (rand_bits(2) != 0);
      end
    end
  end

  // Scoreboard checked before the pop edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && valid_o && ready_i) begin
        if (expected_q.size() == 0) begin
          $display("Errors found");
          $fatal(1, "A result came out with no expected result left");
        end else begin
          check_equal(busy_o, 1'b1, "busy_o while a result waits");
          check_equal(oup_o, expected_q.pop_front(), "result");
        end
      end
    end
  end

  initial begin
    repeat (NumRows * 15 * 40 + 1000) @(posedge clk_i);
    $display("Errors found");
    $fatal(1, "Timeout, the engine did not finish the operations in time");
  end

  initial begin
    int n_tiles;
    int n_ops;
    rst_ni = 1'b0;
    ctrl_i = '0;
    inp_valid_i = 1'b0;
    inp_i = '0;
    weight_valid_i = 1'b0;
    weight_i = '0;
    bias_valid_i = 1'b0;
    bias_i = '0;
    long_stalls = 1'b0;
    lfsr_state = 32'h33012b54;
    fill_table();
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_equal(valid_o, 1'b0, "valid_o after reset");
    check_equal(busy_o, 1'b0, "busy_o after reset");
    check_equal({inp_ready_o, weight_ready_o, bias_ready_o}, 3'b111, "readies after reset");
    for (int r = 0; r < NumRows; r++) begin
      @(posedge clk_i);
      #1;
      ctrl_i = op_table[r].ctrl;
      long_stalls = op_table[r].long_stalls;
      build_row(op_table[r]);
      n_ops = op_table[r].ops;
      n_tiles = n_ops * op_table[r].ctrl.tiles;
      @(posedge clk_i);
      fork
        send_stream(0, n_tiles);
        send_stream(1, n_tiles);
        send_stream(2, n_ops);
      join
      do @(posedge clk_i); while (expected_q.size() != 0);
      @(negedge clk_i);
      check_equal(busy_o, 1'b0, "busy_o after the last result");
    end
    repeat (20) @(negedge clk_i);
    check_equal(valid_o, 1'b0, "valid_o at the end");
    check_equal(busy_o, 1'b0, "busy_o at the end");
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/dotp_engine.sv */
// Top level of the tiled matrix-vector engine
`timescale 1ns/100ps
`default_nettype none

module dotp_engine #(
  parameter int unsigned N         = dotp_pkg::N,
  parameter int unsigned M         = dotp_pkg::M,
  parameter int unsigned FifoDepth = dotp_pkg::FifoDepth
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  dotp_pkg::ctrl_t   ctrl_i,
  input  logic              inp_valid_i,
  output logic              inp_ready_o,
  input  dotp_pkg::inp_t    inp_i,
  input  logic              weight_valid_i,
  output logic              weight_ready_o,
  input  dotp_pkg::weight_t weight_i,
  input  logic              bias_valid_i,
  output logic              bias_ready_o,
  input  dotp_pkg::bias_t   bias_i,
  output logic              valid_o,
  input  logic              ready_i,
  output dotp_pkg::oup_t    oup_o,
  output logic              busy_o
);
  import dotp_pkg::*;

  logic        smp_valid, smp_ready, first_tile;
  inp_t        smp_inp;
  bias_t       smp_bias;
  logic        wgt_valid, wgt_ready;
  weight_t     wgt_data;
  logic        acc_valid;
  acc_vec_t    acc;
  logic        rq_valid;
  oup_t        rq_data;
  fifo_usage_t fifo_free;

  dotp_input_sampler #(.N(N), .M(M)) u_input_sampler (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .inp_valid_i  (inp_valid_i),
    .inp_ready_o  (inp_ready_o),
    .inp_i        (inp_i),
    .bias_valid_i (bias_valid_i),
    .bias_ready_o (bias_ready_o),
    .bias_i       (bias_i),
    .first_tile_i (first_tile),
    .smp_valid_o  (smp_valid),
    .smp_ready_i  (smp_ready),
    .smp_inp_o    (smp_inp),
    .smp_bias_o   (smp_bias)
  );

  dotp_weight_buffer #(.N(N), .M(M)) u_weight_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .weight_valid_i (weight_valid_i),
    .weight_ready_o (weight_ready_o),
    .weight_i       (weight_i),
    .wgt_valid_o    (wgt_valid),
    .wgt_ready_i    (wgt_ready),
    .wgt_data_o     (wgt_data)
  );

  dotp_mac_array #(.N(N), .M(M), .FifoDepth(FifoDepth)) u_mac_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctrl_tiles_i (ctrl_i.tiles),
    .smp_valid_i  (smp_valid),
    .smp_ready_o  (smp_ready),
    .smp_inp_i    (smp_inp),
    .smp_bias_i   (smp_bias),
    .first_tile_o (first_tile),
    .wgt_valid_i  (wgt_valid),
    .wgt_ready_o  (wgt_ready),
    .wgt_data_i   (wgt_data),
    .fifo_free_i  (fifo_free),
    .push_i       (rq_valid),
    .acc_valid_o  (acc_valid),
    .acc_o        (acc),
    .busy_o       (busy_o)
  );

  dotp_requantizer #(.M(M)) u_requantizer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .eps_mult_i    (ctrl_i.eps_mult),
    .right_shift_i (ctrl_i.right_shift),
    .add_i         (ctrl_i.add),
    .acc_valid_i   (acc_valid),
    .acc_i         (acc),
    .rq_valid_o    (rq_valid),
    .rq_data_o     (rq_data)
  );

  dotp_output_fifo #(.M(M), .FifoDepth(FifoDepth)) u_output_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rq_valid),
    .data_i  (rq_data),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (oup_o),
    .free_o  (fifo_free)
  );

endmodule

`default_nettype wire

/* verilog/dotp_input_sampler.sv */
// Input sampler with one input vector slot and one bias slot
`timescale 1ns/100ps
`default_nettype none

module dotp_input_sampler #(
  parameter int unsigned N = dotp_pkg::N,
  parameter int unsigned M = dotp_pkg::M
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            inp_valid_i,
  output logic            inp_ready_o,
  input  dotp_pkg::inp_t  inp_i,
  input  logic            bias_valid_i,
  output logic            bias_ready_o,
  input  dotp_pkg::bias_t bias_i,
  input  logic            first_tile_i,
  output logic            smp_valid_o,
  input  logic            smp_ready_i,
  output dotp_pkg::inp_t  smp_inp_o,
  output dotp_pkg::bias_t smp_bias_o
);
  import dotp_pkg::*;

  slot_e inp_state_q;
  slot_e bias_state_q;
  inp_t  inp_q;
  bias_t bias_q;
  logic  inp_load;
  logic  bias_load;
  logic  bias_pop;

  if ($bits(inp_t) != N * 8 || $bits(bias_t) != M * 24) begin : gen_size_check
    $error("Input or bias type does not match N and M");
  end

  assign bias_pop     = smp_ready_i && first_tile_i;
  assign inp_ready_o  = (inp_state_q == Empty) || smp_ready_i;
  assign bias_ready_o = (bias_state_q == Empty) || bias_pop;
  assign inp_load     = inp_valid_i && inp_ready_o;
  assign bias_load    = bias_valid_i && bias_ready_o;

  // Bias only needed on the first tile
  assign smp_valid_o = (inp_state_q == Full) && (!first_tile_i || bias_state_q == Full);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      inp_state_q  <= Empty;
      bias_state_q <= Empty;
    end else begin
      if (inp_load) begin
        inp_state_q <= Full;
      end else if (smp_ready_i) begin
        inp_state_q <= Empty;
      end
      if (bias_load) begin
        bias_state_q <= Full;
      end else if (bias_pop) begin
        bias_state_q <= Empty;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (inp_load) begin
      inp_q <= inp_i;
    end
    if (bias_load) begin
      bias_q <= bias_i;
    end
  end

  assign smp_inp_o  = inp_q;
  assign smp_bias_o = bias_q;

  // Array only fires on a complete sample
  assert property (@(posedge clk_i) disable iff (!rst_ni) smp_ready_i |-> smp_valid_o)
    else $error("Sampler popped without a valid sample");

endmodule

`default_nettype wire

/* verilog/dotp_mac_array.sv */
// MAC array with tile counting, product and accumulate stages,
// and output credit for results in flight
`timescale 1ns/100ps
`default_nettype none

module dotp_mac_array #(
  parameter int unsigned N         = dotp_pkg::N,
  parameter int unsigned M         = dotp_pkg::M,
  parameter int unsigned FifoDepth = dotp_pkg::FifoDepth
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dotp_pkg::tile_cnt_t   ctrl_tiles_i,
  input  logic                  smp_valid_i,
  output logic                  smp_ready_o,
  input  dotp_pkg::inp_t        smp_inp_i,
  input  dotp_pkg::bias_t       smp_bias_i,
  output logic                  first_tile_o,
  input  logic                  wgt_valid_i,
  output logic                  wgt_ready_o,
  input  dotp_pkg::weight_t     wgt_data_i,
  input  dotp_pkg::fifo_usage_t fifo_free_i,
  input  logic                  push_i,
  output logic                  acc_valid_o,
  output dotp_pkg::acc_vec_t    acc_o,
  output logic                  busy_o
);
  import dotp_pkg::*;

  tile_cnt_t   tile_cnt_q;
  fifo_usage_t inflight_q;
  logic        last_tile;
  logic        fire;

  logic signed [15:0] prod_q [M][N];
  bias_t              bias_q;
  logic               s1_valid_q;
  logic               s1_first_q;
  logic               s1_last_q;

  acc_t     row_sum [M];
  acc_vec_t acc_q;
  logic     acc_valid_q;

  assign first_tile_o = (tile_cnt_q == '0);
  assign last_tile    = (tile_cnt_q == ctrl_tiles_i - tile_cnt_t'(1));

  // Last tile waits for a free FIFO slot not yet claimed
  assign fire        = smp_valid_i && wgt_valid_i && (!last_tile || fifo_free_i > inflight_q);
  assign smp_ready_o = fire;
  assign wgt_ready_o = fire;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      tile_cnt_q <= '0;
      inflight_q <= '0;
    end else begin
      if (fire) begin
        tile_cnt_q <= last_tile ? '0 : tile_cnt_q + tile_cnt_t'(1);
      end
      case ({fire && last_tile, push_i})
        2'b10:   inflight_q <= inflight_q + fifo_usage_t'(1);
        2'b01:   inflight_q <= inflight_q - fifo_usage_t'(1);
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // Flags travel alongside both pipeline stages
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q  <= 1'b0;
      s1_first_q  <= 1'b0;
      s1_last_q   <= 1'b0;
      acc_valid_q <= 1'b0;
    end else begin
      s1_valid_q  <= fire;
      s1_first_q  <= first_tile_o;
      s1_last_q   <= last_tile;
      acc_valid_q <= s1_valid_q && s1_last_q;
    end
  end

  // Stage 1, signed products
  always_ff @(posedge clk_i) begin
    if (fire) begin
      for (int m = 0; m < M; m++) begin
        for (int n = 0; n < N; n++) begin
          prod_q[m][n] <= smp_inp_i[n] * wgt_data_i[m][n];
        end
      end
      if (first_tile_o) begin
        bias_q <= smp_bias_i;
      end
    end
  end

  always_comb begin
    for (int m = 0; m < M; m++) begin
      row_sum[m] = '0;
      for (int n = 0; n < N; n++) begin
        row_sum[m] = row_sum[m] + acc_t'(prod_q[m][n]);
      end
    end
  end

  // Stage 2, bias is loaded with the first tile
  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      for (int m = 0; m < M; m++) begin
        acc_q[m] <= s1_first_q ? bias_q[m] + row_sum[m] : acc_q[m] + row_sum[m];
      end
    end
  end

  assign acc_valid_o = acc_valid_q;
  assign acc_o       = acc_q;
  assign busy_o      = (tile_cnt_q != '0) || (inflight_q != '0) ||
                       (fifo_free_i < fifo_usage_t'(FifoDepth));

  // Claimed credit never exceeds the free FIFO slots
  assert property (@(posedge clk_i) disable iff (!rst_ni) inflight_q <= fifo_free_i)
    else $error("Output credit overcommitted");

endmodule

`default_nettype wire

/* verilog/dotp_output_fifo.sv */
// Result FIFO, circular buffer with valid/ready output and free count
`timescale 1ns/100ps
`default_nettype none

module dotp_output_fifo #(
  parameter int unsigned M         = dotp_pkg::M,
  parameter int unsigned FifoDepth = dotp_pkg::FifoDepth
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  dotp_pkg::oup_t        data_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output dotp_pkg::oup_t        data_o,
  output dotp_pkg::fifo_usage_t free_o
);
  import dotp_pkg::*;

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  oup_t            mem_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  fifo_usage_t     count_q;
  logic            pop;

  if ($bits(oup_t) != M * 8 || FifoDepth >= 2 ** $bits(fifo_usage_t)) begin : gen_size_check
    $error("Result type or FIFO depth does not fit the package types");
  end

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + PtrW'(1);
  endfunction

  assign valid_o = (count_q != '0);
  assign pop     = valid_o && ready_i;
  assign data_o  = mem_q[rd_ptr_q];
  assign free_o  = fifo_usage_t'(FifoDepth) - count_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + fifo_usage_t'(1);
        2'b01:   count_q <= count_q - fifo_usage_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Credit in the array keeps pushes away from a full FIFO
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   push_i |-> count_q < fifo_usage_t'(FifoDepth))
    else $error("Push into a full result FIFO");

endmodule

`default_nettype wire

/* verilog/dotp_pkg.sv */
// Shared sizes, lane and vector types, control struct and slot states
// for the tiled matrix-vector engine
`default_nettype none

package dotp_pkg;

  // Default sizes, overridden through the top level parameters
  localparam int unsigned N         = 4;
  localparam int unsigned M         = 4;
  localparam int unsigned FifoDepth = 4;

  // One signed 8-bit lane
  typedef logic signed [7:0] int8_t;

  // N inputs per vector, M weight rows of N values
  typedef int8_t [N-1:0] inp_t;
  typedef inp_t  [M-1:0] weight_t;

  // Accumulator lane and the per-row vectors built from it
  typedef logic signed [23:0] acc_t;
  typedef acc_t [M-1:0]       acc_vec_t;
  typedef acc_t [M-1:0]       bias_t;

  // Requantized results, one per row
  typedef int8_t [M-1:0] oup_t;

  typedef logic [3:0]        tile_cnt_t;
  typedef logic [7:0]        eps_mult_t;
  typedef logic [4:0]        right_shift_t;
  typedef logic signed [7:0] add_t;

  // Holds 0 to FifoDepth entries
  typedef logic [2:0] fifo_usage_t;

  // Operation settings, stable while the engine is busy
  typedef struct packed {
    tile_cnt_t    tiles;
    eps_mult_t    eps_mult;
    right_shift_t right_shift;
    add_t         add;
  } ctrl_t;

  typedef enum logic {
    Empty,
    Full
  } slot_e;

endpackage

`default_nettype wire

/* verilog/dotp_requantizer.sv */
// Requantizer with multiply, arithmetic shift, offset and
// saturation to signed 8 bits, one register stage
`timescale 1ns/100ps
`default_nettype none

module dotp_requantizer #(
  parameter int unsigned M = dotp_pkg::M
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  dotp_pkg::eps_mult_t    eps_mult_i,
  input  dotp_pkg::right_shift_t right_shift_i,
  input  dotp_pkg::add_t         add_i,
  input  logic                   acc_valid_i,
  input  dotp_pkg::acc_vec_t     acc_i,
  output logic                   rq_valid_o,
  output dotp_pkg::oup_t         rq_data_o
);
  import dotp_pkg::*;

  logic signed [32:0] scaled [M];
  logic signed [33:0] offset [M];
  oup_t               rq_d;
  oup_t               rq_q;
  logic               rq_valid_q;

  always_comb begin
    for (int m = 0; m < M; m++) begin
      scaled[m] = acc_i[m] * $signed({1'b0, eps_mult_i});
      // Arithmetic shift rounds toward minus infinity
      offset[m] = (scaled[m] >>> right_shift_i) + add_i;
      if (offset[m] > 34'sd127) begin
        rq_d[m] = 8'sd127;
      end else if (offset[m] < -34'sd128) begin
        rq_d[m] = -8'sd128;
      end else begin
        rq_d[m] = offset[m][7:0];
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rq_valid_q <= 1'b0;
    end else begin
      rq_valid_q <= acc_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      rq_q <= rq_d;
    end
  end

  assign rq_valid_o = rq_valid_q;
  assign rq_data_o  = rq_q;

endmodule

`default_nettype wire

/* verilog/dotp_weight_buffer.sv */
// Single-entry holding register for one weight tile
`timescale 1ns/100ps
`default_nettype none

module dotp_weight_buffer #(
  parameter int unsigned N = dotp_pkg::N,
  parameter int unsigned M = dotp_pkg::M
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              weight_valid_i,
  output logic              weight_ready_o,
  input  dotp_pkg::weight_t weight_i,
  output logic              wgt_valid_o,
  input  logic              wgt_ready_i,
  output dotp_pkg::weight_t wgt_data_o
);
  import dotp_pkg::*;

  logic    valid_q;
  weight_t data_q;
  logic    load;

  if ($bits(weight_t) != M * N * 8) begin : gen_size_check
    $error("Weight tile type does not match M rows of N lanes");
  end

  // Refill allowed in the cycle the held tile is consumed
  assign weight_ready_o = !valid_q || wgt_ready_i;
  assign load           = weight_valid_i && weight_ready_o;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (wgt_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= weight_i;
    end
  end

  assign wgt_valid_o = valid_q;
  assign wgt_data_o  = data_q;

endmodule

`default_nettype wire
